// ==== src/rotmask_pkg.sv ====
// Shared types for the rotate-and-mask unit
// Word and bit position types, op codes, request/control/result structs

`default_nettype none

package rotmask_pkg;

   ////////////////////
   // Basic widths
   ////////////////////

   typedef logic [31:0] word_t;    // Architectural data word
   typedef logic [4:0]  bitpos_t;  // Bit index or rotate amount
   typedef logic [2:0]  op_t;      // Unit op code

   localparam word_t WORD_ZERO = 32'h0000_0000;  // All clear
   localparam word_t WORD_ONES = 32'hffff_ffff;  // All set, for sign fill

   ////////////////////
   // Op codes
   ////////////////////

   // rlwinm and srawi arrive here as rlwnm/sraw, with the immediate in rb
   localparam op_t OP_RLWNM = 3'd0;  // Rotate, AND with mask
   localparam op_t OP_SLW   = 3'd1;  // Shift left word
   localparam op_t OP_SRW   = 3'd2;  // Logical shift right word
   localparam op_t OP_SRAW  = 3'd3;  // Arithmetic shift right, sets CA

   ////////////////////
   // Structs
   ////////////////////

   typedef struct packed {
      op_t     op;  // Operation
      word_t   rs;  // Source word
      word_t   rb;  // Shift operand, [5] flags 32..63
      bitpos_t mb;  // Mask begin, IBM numbering
      bitpos_t me;  // Mask end, IBM numbering
   } rm_req_t;

   typedef struct packed {
      bitpos_t rol_amount;  // Left rotate count
      bitpos_t mask_start;  // Upper mask bound, bit 0 is LSB
      bitpos_t mask_stop;   // Lower mask bound, may wrap
      logic    big_shift;   // Shift amount 32 or more
      logic    zero_shift;  // Shift amount zero
      logic    op_ok;       // Op is a defined code
   } rm_ctrl_t;

   typedef struct packed {
      word_t value;  // Result word
      logic  ca;     // Carry out, sraw only
   } rm_res_t;

endpackage

`default_nettype wire

// ==== src/shift_control.sv ====
// Op decode for the rotate-and-mask unit
// Produces rotate amount, mask bounds and limit-case flags

`default_nettype none

module shift_control (
   input  wire rotmask_pkg::rm_req_t  req,   // Incoming request
   output      rotmask_pkg::rm_ctrl_t ctrl   // Control to datapath and merge
);
   import rotmask_pkg::*;

   bitpos_t n;       // Shift amount from rb
   bitpos_t n_right; // 32-n, 0 maps to 0
   logic    n_big;   // rb[5], amount 32..63

   assign n       = req.rb[4:0];
   assign n_big   = req.rb[5];
   assign n_right = bitpos_t'(6'd32 - {1'b0, n});  // Right shift as left rotate

   ////////////////////
   // Decode
   ////////////////////

   always_comb begin
      ctrl = '0;  // Undefined ops leave everything clear
      case (req.op)
         OP_RLWNM: begin
            ctrl.rol_amount = n;
            // Convert IBM numbering to LSB-first
            ctrl.mask_start = 5'd31 - req.mb;
            ctrl.mask_stop  = 5'd31 - req.me;
            ctrl.op_ok      = 1'b1;
         end
         OP_SLW: begin
            ctrl.rol_amount = n;
            ctrl.mask_start = n - 5'd1;  // Bits n-1..0 get cleared
            ctrl.mask_stop  = 5'd0;      // n=0 wraps, covered by zero_shift
            ctrl.big_shift  = n_big;
            ctrl.zero_shift = (n == 5'd0);
            ctrl.op_ok      = 1'b1;
         end
         OP_SRW,
         OP_SRAW: begin
            ctrl.rol_amount = n_right;
            ctrl.mask_start = 5'd31;     // Top bits vacated by the shift
            ctrl.mask_stop  = n_right;   // Down to 32-n
            ctrl.big_shift  = n_big;
            ctrl.zero_shift = (n == 5'd0);
            ctrl.op_ok      = 1'b1;
         end
         default: begin
            ctrl = '0;  // Merge forces zero result
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== src/rotate_mask_path.sv ====
// Datapath of the rotate-and-mask unit
// Five-stage left rotator and wrapping mask generator

`default_nettype none

module rotate_mask_path (
   input  wire rotmask_pkg::word_t    rs,       // Word to rotate
   input  wire rotmask_pkg::rm_ctrl_t ctrl,     // Rotate amount and mask bounds
   output      rotmask_pkg::word_t    rotated,  // rs rotated left
   output      rotmask_pkg::word_t    mask      // Mask, start down to stop
);
   import rotmask_pkg::*;

   word_t   rot_16;  // After 16-bit stage
   word_t   rot_8;   // After 8-bit stage
   word_t   rot_4;   // After 4-bit stage
   word_t   rot_2;   // After 2-bit stage
   bitpos_t amt;     // Rotate count
   bitpos_t start;   // Upper mask bound
   bitpos_t stop;    // Lower mask bound
   logic    wraps;   // Ones run through bit 0 into bit 31

   assign amt   = ctrl.rol_amount;
   assign start = ctrl.mask_start;
   assign stop  = ctrl.mask_stop;
   assign wraps = (start < stop);

   ////////////////////
   // Rotator
   ////////////////////

   // One stage per amount bit, largest first
   assign rot_16  = amt[4] ? {rs[15:0], rs[31:16]}       : rs;
   assign rot_8   = amt[3] ? {rot_16[23:0], rot_16[31:24]} : rot_16;
   assign rot_4   = amt[2] ? {rot_8[27:0], rot_8[31:28]}   : rot_8;
   assign rot_2   = amt[1] ? {rot_4[29:0], rot_4[31:30]}   : rot_4;
   assign rotated = amt[0] ? {rot_2[30:0], rot_2[31]}      : rot_2;

   ////////////////////
   // Mask generator
   ////////////////////

   // Each bit compares its own index against both bounds
   always_comb begin
      bitpos_t idx;  // Current bit index
      mask = WORD_ZERO;
      for (int i = 0; i < 32; i++) begin
         idx = bitpos_t'(i);
         if (wraps) begin
            mask[i] = (idx <= start) || (idx >= stop);  // Two runs
         end else begin
            mask[i] = (idx <= start) && (idx >= stop);  // Single run
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/result_merge.sv ====
// Result stage of the rotate-and-mask unit
// Per-op combine of rotated word and mask, limit cases, sraw carry

`default_nettype none

module result_merge (
   input  wire rotmask_pkg::op_t      op,       // Operation
   input  wire rotmask_pkg::word_t    rs,       // Original source word
   input  wire rotmask_pkg::rm_ctrl_t ctrl,     // Flags from decode
   input  wire rotmask_pkg::word_t    rotated,  // Rotator output
   input  wire rotmask_pkg::word_t    mask,     // Mask generator output
   output      rotmask_pkg::rm_res_t  res       // Next result
);
   import rotmask_pkg::*;

   logic  sign;         // Sign of rs
   word_t shifted_out;  // Low bits that sraw drops
   word_t zext;         // Vacated bits cleared
   word_t sext;         // Vacated bits set

   assign sign        = rs[31];
   // Bits shifted out of the bottom reappear at the top after the rotate
   assign shifted_out = rotated & mask;
   assign zext        = rotated & ~mask;
   assign sext        = rotated | mask;

   ////////////////////
   // Select
   ////////////////////

   always_comb begin
      res = '0;  // ca stays 0 unless sraw sets it
      if (ctrl.op_ok) begin
         case (op)
            OP_RLWNM: begin
               res.value = rotated & mask;
            end
            OP_SLW,
            OP_SRW: begin
               if (ctrl.big_shift) begin
                  res.value = WORD_ZERO;  // Everything shifted away
               end else if (ctrl.zero_shift) begin
                  res.value = rs;         // Mask would wrap, bypass
               end else begin
                  res.value = zext;
               end
            end
            OP_SRAW: begin
               if (ctrl.big_shift) begin
                  res.value = sign ? WORD_ONES : WORD_ZERO;  // Sign fill
                  res.ca    = sign;
               end else if (ctrl.zero_shift) begin
                  res.value = rs;  // Nothing shifted out, ca 0
               end else begin
                  res.value = sign ? sext : zext;
                  // Negative and lost a one bit
                  res.ca    = sign & (|shifted_out);
               end
            end
            default: begin
               res = '0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/rotmask_unit.sv ====
// Rotate-and-mask execute unit, top level
// Decode, datapath and merge instances plus the output register

`default_nettype none

module rotmask_unit (
   input  wire                       clk,        // Core clock
   input  wire                       rst,        // Sync reset, active high
   input  wire                       in_valid,   // Request strobe
   input  wire rotmask_pkg::rm_req_t req,        // Request
   output logic                      out_valid,  // Result strobe, 1 cycle later
   output      rotmask_pkg::rm_res_t res         // Registered result
);
   import rotmask_pkg::*;

   rm_ctrl_t ctrl;      // Decoded control
   word_t    rotated;   // Rotator output
   word_t    mask;      // Mask output
   rm_res_t  res_next;  // Combinational result

   ////////////////////
   // Datapath
   ////////////////////

   shift_control shift_control_i (
      .req  (req),
      .ctrl (ctrl)
   );

   rotate_mask_path rotate_mask_path_i (
      .rs      (req.rs),
      .ctrl    (ctrl),
      .rotated (rotated),
      .mask    (mask)
   );

   result_merge result_merge_i (
      .op      (req.op),
      .rs      (req.rs),
      .ctrl    (ctrl),
      .rotated (rotated),
      .mask    (mask),
      .res     (res_next)
   );

   ////////////////////
   // Output register
   ////////////////////

   // One item per cycle, no stall; res holds across idle cycles
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
         res       <= '0;  // Clean value after reset
      end else begin
         out_valid <= in_valid;  // Single-cycle pulse per item
         if (in_valid) begin
            res <= res_next;     // Capture only real items
         end
      end
   end

endmodule

`default_nettype wire

// ==== verif/rotmask_props.sv ====
// Bound assertions for the rotate-and-mask unit
// Valid timing around reset and per item, carry only on sraw

`default_nettype none

module rotmask_props (
   input wire                       clk,        // Unit clock
   input wire                       rst,        // Sync reset
   input wire                       in_valid,   // Request strobe
   input wire rotmask_pkg::rm_req_t req,        // Request
   input wire                       out_valid,  // Result strobe
   input wire rotmask_pkg::rm_res_t res         // Registered result
);
   import rotmask_pkg::*;

   // Quiet while in reset and in the cycle right after it
   a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> !out_valid)
      else $error("out_valid high during or right after reset");

   // One cycle of latency, one pulse per item
   a_valid_delay: assert property (@(posedge clk) disable iff (rst)
      !$past(rst) |-> (out_valid == $past(in_valid)))
      else $error("out_valid does not follow in_valid by one cycle");

   // Carry only comes out of sraw
   a_ca_sraw_only: assert property (@(posedge clk) disable iff (rst)
      (!$past(rst) && $past(in_valid) && ($past(req.op) != OP_SRAW)) |-> !res.ca)
      else $error("ca set on an item that was not sraw");

endmodule

bind rotmask_unit rotmask_props props_i (
   .clk       (clk),
   .rst       (rst),
   .in_valid  (in_valid),
   .req       (req),
   .out_valid (out_valid),
   .res       (res)
);

`default_nettype wire

// ==== verif/rotmask_tb.sv ====
// Testbench for the rotate-and-mask unit
// Directed table, seeded random phase against a reference model, checks

`default_nettype none

module rotmask_tb;
   import rotmask_pkg::*;

   localparam int NUM_VECS = 22;    // Directed entries
   localparam int NUM_RAND = 300;   // Random cycles
   localparam int WATCHDOG = 1000;  // Cycle limit for the whole run

   typedef struct packed {
      op_t     op;
      word_t   rs;
      word_t   rb;
      bitpos_t mb;
      bitpos_t me;
      word_t   value;  // Expected result
      logic    ca;     // Expected carry
   } vec_t;

   // op, rs, rb, mb, me, value, ca
   localparam vec_t VECS [NUM_VECS] = '{
      '{OP_RLWNM, 32'h1234_5678, 32'd8,  5'd24, 5'd31, 32'h0000_0012, 1'b0},  // Low byte
      '{OP_RLWNM, 32'h1234_5678, 32'd4,  5'd0,  5'd31, 32'h2345_6781, 1'b0},  // Full rotate
      '{OP_RLWNM, 32'hdead_beef, 32'd0,  5'd24, 5'd7,  32'hde00_00ef, 1'b0},  // Wrapping
      '{OP_RLWNM, 32'h8000_0001, 32'd33, 5'd31, 5'd0,  32'h0000_0001, 1'b0},  // Ends only
      '{OP_SLW,   32'h1234_5678, 32'd0,  5'd0,  5'd0,  32'h1234_5678, 1'b0},
      '{OP_SLW,   32'h1234_5678, 32'd1,  5'd0,  5'd0,  32'h2468_acf0, 1'b0},
      '{OP_SLW,   32'h1234_5679, 32'd31, 5'd0,  5'd0,  32'h8000_0000, 1'b0},
      '{OP_SLW,   32'h1234_5678, 32'd32, 5'd0,  5'd0,  32'h0000_0000, 1'b0},
      '{OP_SLW,   32'h1234_5678, 32'd63, 5'd0,  5'd0,  32'h0000_0000, 1'b0},
      '{OP_SRW,   32'h8765_4321, 32'd0,  5'd0,  5'd0,  32'h8765_4321, 1'b0},
      '{OP_SRW,   32'h8765_4321, 32'd1,  5'd0,  5'd0,  32'h43b2_a190, 1'b0},
      '{OP_SRW,   32'h8765_4321, 32'd31, 5'd0,  5'd0,  32'h0000_0001, 1'b0},
      '{OP_SRW,   32'h8765_4321, 32'd32, 5'd0,  5'd0,  32'h0000_0000, 1'b0},
      '{OP_SRW,   32'h8765_4321, 32'd63, 5'd0,  5'd0,  32'h0000_0000, 1'b0},
      '{3'd4,     32'hffff_ffff, 32'd1,  5'd0,  5'd0,  32'h0000_0000, 1'b0},  // Undefined
      '{3'd7,     32'h1234_5678, 32'd40, 5'd3,  5'd9,  32'h0000_0000, 1'b0},
      '{OP_SRAW,  32'h7fff_0010, 32'd4,  5'd0,  5'd0,  32'h07ff_f001, 1'b0},  // Positive
      '{OP_SRAW,  32'h8000_0010, 32'd4,  5'd0,  5'd0,  32'hf800_0001, 1'b0},  // Zeros lost
      '{OP_SRAW,  32'h8000_0011, 32'd4,  5'd0,  5'd0,  32'hf800_0001, 1'b1},  // One lost
      '{OP_SRAW,  32'h7fff_ffff, 32'd63, 5'd0,  5'd0,  32'h0000_0000, 1'b0},
      '{OP_SRAW,  32'h8000_0001, 32'd0,  5'd0,  5'd0,  32'h8000_0001, 1'b0},
      '{OP_SRAW,  32'h8000_0000, 32'd32, 5'd0,  5'd0,  32'hffff_ffff, 1'b1}   // Sign fill
   };

   logic    clk;
   logic    rst;
   logic    in_valid;
   rm_req_t req;
   logic    out_valid;
   rm_res_t res;
   integer  seed;  // $random state
   rm_res_t held;  // Result the register must keep when idle

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   rotmask_unit dut_i (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .req       (req),
      .out_valid (out_valid),
      .res       (res)
   );

   ////////////////////
   // Checks
   ////////////////////

   task automatic check_word(input string name, input word_t got, input word_t want);
      if (got !== want) begin
         $display("Error at time %0t: %s is %h, expected %h", $time, name, got, want);
         $display("Test failed");
         $fatal(1, "Wrong value on %s", name);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      if (got !== want) begin
         $display("Error at time %0t: %s is %b, expected %b", $time, name, got, want);
         $display("Test failed");
         $fatal(1, "Wrong value on %s", name);
      end
   endtask

   // Drive at the falling edge and check the register one edge later
   task automatic run_cycle(input logic valid, input rm_req_t r, input rm_res_t want);
      in_valid = valid;
      req      = r;
      if (valid) begin
         held = want;  // Idle cycles keep the old value
      end
      @(negedge clk);
      check_bit("out_valid", out_valid, valid);
      check_word("res.value", res.value, held.value);
      check_bit("res.ca", res.ca, held.ca);
   endtask

   // Reference model from the ISA rules where IBM bit k is bit 31-k
   function automatic rm_res_t expected_result(input rm_req_t r);
      rm_res_t e;
      word_t   rot;
      word_t   mask;
      bitpos_t n;
      bitpos_t kb;
      e    = '0;
      n    = r.rb[4:0];
      rot  = (r.rs << n) | (r.rs >> (6'd32 - {1'b0, n}));  // n=0 leaves rs
      mask = '0;
      for (int k = 0; k < 32; k++) begin
         kb = bitpos_t'(k);
         mask[5'd31 - kb] = (r.mb <= r.me) ? (kb >= r.mb && kb <= r.me)
                                           : (kb >= r.mb || kb <= r.me);
      end
      case (r.op)
         OP_RLWNM: e.value = rot & mask;
         OP_SLW:   e.value = r.rb[5] ? WORD_ZERO : r.rs << n;
         OP_SRW:   e.value = r.rb[5] ? WORD_ZERO : r.rs >> n;
         OP_SRAW: begin
            e.value = r.rb[5] ? {32{r.rs[31]}} : word_t'($signed(r.rs) >>> n);
            e.ca    = r.rs[31] & (r.rb[5] | (|(r.rs & ~(WORD_ONES << n))));  // Ones lost
         end
         default: e = '0;
      endcase
      return e;
   endfunction

   ////////////////////
   // Sequence
   ////////////////////

   initial begin
      rm_req_t r;
      rm_res_t want;
      word_t   pick;
      seed     = 32'h48e8;
      rst      = 1'b1;
      in_valid = 1'b0;
      req      = '0;
      held     = '0;
      for (int c = 0; c < 4; c++) begin
         @(negedge clk);
      end
      rst = 1'b0;
      run_cycle(1'b0, '0, '0);  // Clean state after reset
      for (int i = 0; i < NUM_VECS; i++) begin
         r.op       = VECS[i].op;
         r.rs       = VECS[i].rs;
         r.rb       = VECS[i].rb;
         r.mb       = VECS[i].mb;
         r.me       = VECS[i].me;
         want.value = VECS[i].value;
         want.ca    = VECS[i].ca;
         run_cycle(1'b1, r, want);  // Back to back
      end
      run_cycle(1'b0, '1, '0);  // Idle gap keeps res
      run_cycle(1'b0, '0, '0);
      for (int i = 0; i < NUM_RAND; i++) begin
         pick = $random(seed);
         r.op = pick[3] ? pick[2:0] : {1'b0, pick[1:0]};  // Mostly defined ops
         r.rs = $random(seed);
         r.rb = $random(seed);
         if (pick[16]) begin
            r.rb[31:5] = '0;  // Favor in-range amounts
         end
         r.mb = pick[8:4];
         r.me = pick[13:9];
         run_cycle(pick[14] | pick[15], r, expected_result(r));
      end
      $display("Test completed successfully");
      $finish;
   end

   initial begin
      for (int c = 0; c < WATCHDOG; c++) begin
         @(posedge clk);
      end
      $display("Test failed");
      $fatal(1, "Timeout, run did not finish within %0d cycles", WATCHDOG);
   end

endmodule

`default_nettype wire

// ==== rotmask_unit.f ====
src/rotmask_pkg.sv
src/shift_control.sv
src/rotate_mask_path.sv
src/result_merge.sv
src/rotmask_unit.sv
verif/rotmask_props.sv
verif/rotmask_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rotmask_tb
FILELIST  ?= rotmask_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
